//--- sl_pkg.sv
// scanline emulation package
// channel widths, scanline thresholds, pipeline latencies and shared types

`default_nettype none

package sl_pkg;

  localparam int COLOR_W = 8;

  typedef logic [COLOR_W-1:0] pixel_t;
  typedef logic [COLOR_W:0]   luma_t;  // one bit headroom for g + (r+b)/2

  // one pixel of the video stream with its timing
  typedef struct packed {
    logic   hsync;
    logic   vsync;
    logic   de;
    pixel_t red;
    pixel_t green;
    pixel_t blue;
  } video_t;

  typedef enum logic [1:0] {
    TH_DEFAULT = 2'b00,  // handled as normal
    TH_THIN    = 2'b01,
    TH_NORMAL  = 2'b10,
    TH_THICK   = 2'b11
  } sl_thickness_e;

  typedef enum logic [1:0] {
    PR_HANN  = 2'b00,  // handled as rect
    PR_GAUSS = 2'b01,  // handled as rect
    PR_RECT  = 2'b10,
    PR_FLAT  = 2'b11
  } sl_profile_e;

  // positions in 1/256 of a line with 8'h80 at the line center
  localparam pixel_t OFS_THIN       = 8'h30;
  localparam pixel_t OFS_NORMAL     = 8'h20;
  localparam pixel_t OFS_THICK      = 8'h10;
  localparam pixel_t PROFILE_W      = 8'h40;
  localparam pixel_t HALF_PROFILE_W = 8'h20;
  localparam pixel_t FLAT_LEVEL     = 8'h80;  // 0.5 strength

  localparam int DECODE_LAT  = 3;
  localparam int EXECUTE_LAT = 4;
  localparam int RESULT_LAT  = 2;
  localparam int PIPE_LAT    = DECODE_LAT + EXECUTE_LAT + RESULT_LAT;

endpackage

`default_nettype wire

//--- sl_cfg_if.sv
// scanline configuration bundle
// decode reads the position and shape, execute reads strength and bloom

`default_nettype none

interface sl_cfg_if;

  import sl_pkg::*;

  logic          en;
  sl_thickness_e thickness;
  sl_profile_e   profile;
  logic [7:0]    rel_pos;   // position inside the current line
  logic [7:0]    strength;
  logic [4:0]    bloom;

  modport dec_mp (
    input en,
    input thickness,
    input profile,
    input rel_pos
  );

  modport exe_mp (
    input strength,
    input bloom
  );

endinterface

`default_nettype wire

//--- sl_decode.sv
// scanline decode
// folds the line position around the center, removes the thickness offset
// and forms the profile value plus the draw and max flags in three stages

`default_nettype none

module sl_decode (
  input  wire             VCLK_i,
  input  wire             nVRST_i,
  sl_cfg_if.dec_mp        cfg,
  output sl_pkg::pixel_t  prof_o,
  output logic            max_o,
  output logic            draw_o
);

  import sl_pkg::*;

  pixel_t fold_r;   // stage 1
  pixel_t ofs;
  pixel_t diff_r;   // stage 2
  logic   flat_r;
  logic   draw_r;
  logic   max_r;

  // offset of the profile start from the line edge
  always_comb begin
    case (cfg.thickness)
      TH_THIN:  ofs = OFS_THIN;
      TH_THICK: ofs = OFS_THICK;
      default:  ofs = OFS_NORMAL;  // normal and default
    endcase
  end

  //////////////////////////////////////////////////
  // decode pipeline

  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i) begin
      fold_r <= '0;
      diff_r <= '0;
      flat_r <= 1'b0;
      draw_r <= 1'b0;
      max_r  <= 1'b0;
      prof_o <= '0;
      max_o  <= 1'b0;
      draw_o <= 1'b0;
    end else begin
      // map the position to 0 .. 0.5
      fold_r <= (cfg.rel_pos > 8'h80) ? 8'h00 - cfg.rel_pos : cfg.rel_pos;

      diff_r <= fold_r - ofs;  // wraps below the offset
      flat_r <= (cfg.profile == PR_FLAT);
      case (cfg.profile)
        PR_FLAT: begin
          draw_r <= fold_r >= ofs + HALF_PROFILE_W;
          max_r  <= fold_r > ofs + HALF_PROFILE_W;
        end
        default: begin  // rect also covers hann and gauss
          draw_r <= fold_r > ofs;
          max_r  <= fold_r >= ofs + PROFILE_W;
        end
      endcase

      // rect ramp is diff scaled by four with the top bits fed back in
      prof_o <= flat_r ? FLAT_LEVEL : {diff_r[5:0], diff_r[5:4]};
      max_o  <= max_r;
      draw_o <= draw_r & cfg.en;
    end
  end

endmodule

`default_nettype wire

//--- sl_execute.sv
// scanline execute
// luma reference, bloom scaling and saturated strength
// combined into the darkening factor applied by the result stage

`default_nettype none

module sl_execute (
  input  wire             VCLK_i,
  input  wire             nVRST_i,
  sl_cfg_if.exe_mp        cfg,
  input  wire sl_pkg::pixel_t red_i,
  input  wire sl_pkg::pixel_t green_i,
  input  wire sl_pkg::pixel_t blue_i,
  input  wire sl_pkg::pixel_t prof_i,
  input  wire             max_i,
  output sl_pkg::pixel_t  factor_o
);

  import sl_pkg::*;

  luma_t       rpb_r;      // r + b
  pixel_t      green_r;
  luma_t       ref_r;      // luma approximation
  luma_t       pre_r;      // bloom scaled reference
  luma_t       pre_d;
  pixel_t      corr_r;     // strength after profile
  pixel_t      corr_d;
  luma_t       vref_r;
  pixel_t      red_r;      // effective reduction
  logic [13:0] pre_full;
  logic [15:0] corr_full;
  logic [16:0] vref_full;

  assign pre_full  = ref_r * cfg.bloom;
  assign corr_full = prof_i * cfg.strength;
  assign vref_full = pre_d * corr_r;

  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i) begin
      rpb_r    <= '0;
      green_r  <= '0;
      ref_r    <= '0;
      pre_r    <= '0;
      pre_d    <= '0;
      corr_r   <= '0;
      corr_d   <= '0;
      vref_r   <= '0;
      red_r    <= '0;
      factor_o <= '0;
    end else begin
      // reference path lines up with decode after three stages
      rpb_r   <= {1'b0, red_i} + {1'b0, blue_i};
      green_r <= green_i;
      ref_r   <= {1'b0, green_r} + {1'b0, rpb_r[COLOR_W:1]};
      pre_r   <= pre_full[13:5];   // bloom in 1/32 steps

      // strength saturates at the profile plateau
      corr_r <= max_i ? cfg.strength : corr_full[15:8];
      pre_d  <= pre_r;

      vref_r <= vref_full[16:8];
      corr_d <= corr_r;

      // bright pixels may cancel the scanline completely
      red_r    <= ({1'b0, corr_d} < vref_r) ? '0 : corr_d - vref_r[COLOR_W-1:0];
      factor_o <= 8'hff - red_r;
    end
  end

endmodule

`default_nettype wire

//--- sl_result.sv
// scanline result stage
// delays the video to meet the factor, scales the channels and
// selects scaled or original pixels for the output

`default_nettype none

module sl_result (
  input  wire                 VCLK_i,
  input  wire                 nVRST_i,
  input  wire                 hsync_i,
  input  wire                 vsync_i,
  input  wire                 de_i,
  input  wire sl_pkg::pixel_t red_i,
  input  wire sl_pkg::pixel_t green_i,
  input  wire sl_pkg::pixel_t blue_i,
  input  wire                 draw_i,
  input  wire sl_pkg::pixel_t factor_i,
  output logic                hsync_o,
  output logic                vsync_o,
  output logic                de_o,
  output logic [3*sl_pkg::COLOR_W-1:0] vdata_o
);

  import sl_pkg::*;

  video_t vid_d [PIPE_LAT-RESULT_LAT];                  // up to the factor
  logic [PIPE_LAT-RESULT_LAT-DECODE_LAT-1:0] draw_d;    // decode flag to the factor
  video_t vid_p;
  logic   draw_p;
  pixel_t red_p, green_p, blue_p;

  function automatic pixel_t scale(input pixel_t pix, input pixel_t f);
    logic [2*COLOR_W-1:0] prod;
    prod = pix * f;
    return prod[2*COLOR_W-1:COLOR_W];
  endfunction

  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i) begin
      for (int i = 0; i < PIPE_LAT-RESULT_LAT; i++) vid_d[i] <= '0;
      draw_d  <= '0;
      vid_p   <= '0;
      draw_p  <= 1'b0;
      red_p   <= '0;
      green_p <= '0;
      blue_p  <= '0;
      hsync_o <= 1'b0;
      vsync_o <= 1'b0;
      de_o    <= 1'b0;
      vdata_o <= '0;
    end else begin
      vid_d[0] <= '{hsync_i, vsync_i, de_i, red_i, green_i, blue_i};
      for (int i = 1; i < PIPE_LAT-RESULT_LAT; i++) vid_d[i] <= vid_d[i-1];
      draw_d <= {draw_d[PIPE_LAT-RESULT_LAT-DECODE_LAT-2:0], draw_i};

      // product stage
      vid_p   <= vid_d[PIPE_LAT-RESULT_LAT-1];
      draw_p  <= draw_d[PIPE_LAT-RESULT_LAT-DECODE_LAT-1];
      red_p   <= scale(vid_d[PIPE_LAT-RESULT_LAT-1].red, factor_i);
      green_p <= scale(vid_d[PIPE_LAT-RESULT_LAT-1].green, factor_i);
      blue_p  <= scale(vid_d[PIPE_LAT-RESULT_LAT-1].blue, factor_i);

      // blanking passes the output select untouched
      hsync_o <= vid_p.hsync;
      vsync_o <= vid_p.vsync;
      de_o    <= vid_p.de;
      if (vid_p.de && draw_p)
        vdata_o <= {red_p, green_p, blue_p};
      else
        vdata_o <= {vid_p.red, vid_p.green, vid_p.blue};
    end
  end

endmodule

`default_nettype wire

//--- scanline_emu.sv
// scanline emulator top
// darkens a 24 bit rgb stream along a configurable crt scanline profile
// fixed latency of nine clocks for video and syncs

`default_nettype none

module scanline_emu (
  input  wire                          VCLK_i,
  input  wire                          nVRST_i,
  input  wire                          HSYNC_i,
  input  wire                          VSYNC_i,
  input  wire                          DE_i,
  input  wire [3*sl_pkg::COLOR_W-1:0]  vdata_i,   // r, g, b from the top
  input  wire                          sl_en_i,
  input  wire sl_pkg::sl_thickness_e   sl_thickness_i,
  input  wire sl_pkg::sl_profile_e     sl_profile_i,
  input  wire [7:0]                    sl_rel_pos_i,
  input  wire [7:0]                    sl_strength_i,
  input  wire [4:0]                    sl_bloom_i,
  output logic                         HSYNC_o,
  output logic                         VSYNC_o,
  output logic                         DE_o,
  output logic [3*sl_pkg::COLOR_W-1:0] vdata_o
);

  import sl_pkg::*;

  pixel_t red_w, green_w, blue_w;
  pixel_t prof_w;
  pixel_t factor_w;
  logic   max_w;
  logic   draw_w;

  sl_cfg_if cfg_if ();

  // configuration is quasi static
  assign cfg_if.en        = sl_en_i;
  assign cfg_if.thickness = sl_thickness_i;
  assign cfg_if.profile   = sl_profile_i;
  assign cfg_if.rel_pos   = sl_rel_pos_i;
  assign cfg_if.strength  = sl_strength_i;
  assign cfg_if.bloom     = sl_bloom_i;

  assign red_w   = vdata_i[3*COLOR_W-1:2*COLOR_W];
  assign green_w = vdata_i[2*COLOR_W-1:COLOR_W];
  assign blue_w  = vdata_i[COLOR_W-1:0];

  //////////////////////////////////////////////////
  // pipeline stages

  sl_decode decode_inst (
    .VCLK_i  (VCLK_i),
    .nVRST_i (nVRST_i),
    .cfg     (cfg_if.dec_mp),
    .prof_o  (prof_w),
    .max_o   (max_w),
    .draw_o  (draw_w)
  );

  sl_execute execute_inst (
    .VCLK_i   (VCLK_i),
    .nVRST_i  (nVRST_i),
    .cfg      (cfg_if.exe_mp),
    .red_i    (red_w),
    .green_i  (green_w),
    .blue_i   (blue_w),
    .prof_i   (prof_w),
    .max_i    (max_w),
    .factor_o (factor_w)
  );

  sl_result result_inst (
    .VCLK_i   (VCLK_i),
    .nVRST_i  (nVRST_i),
    .hsync_i  (HSYNC_i),
    .vsync_i  (VSYNC_i),
    .de_i     (DE_i),
    .red_i    (red_w),
    .green_i  (green_w),
    .blue_i   (blue_w),
    .draw_i   (draw_w),
    .factor_i (factor_w),
    .hsync_o  (HSYNC_o),
    .vsync_o  (VSYNC_o),
    .de_o     (DE_o),
    .vdata_o  (vdata_o)
  );

endmodule

`default_nettype wire

//--- tb_clkgen.sv
// testbench clock and reset
// 40 ns video clock with reset held low for the first two cycles

`default_nettype none

module tb_clkgen (
  output logic VCLK_o,
  output logic nVRST_o
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD  = 20;
  localparam int RESET_CYCLES = 2;

  initial begin
    VCLK_o = 1'b0;
    forever #(HALF_PERIOD) VCLK_o = ~VCLK_o;
  end

  initial begin
    nVRST_o = 1'b0;
    #(RESET_CYCLES * 2 * HALF_PERIOD);
    nVRST_o = 1'b1;  // lands on a falling edge
  end

endmodule

`default_nettype wire

//--- tb_scanline_assertions.sv
// scanline emulator port checks
// syncs, DE and blanked video pass through with the fixed pipeline latency

`default_nettype none

module tb_scanline_assertions (
  input wire                         VCLK_i,
  input wire                         nVRST_i,
  input wire                         hs_in_i,
  input wire                         vs_in_i,
  input wire                         de_in_i,
  input wire [3*sl_pkg::COLOR_W-1:0] vdata_in_i,
  input wire                         hs_out_i,
  input wire                         vs_out_i,
  input wire                         de_out_i,
  input wire [3*sl_pkg::COLOR_W-1:0] vdata_out_i
);

  timeunit 1ns;
  timeprecision 100ps;

  import sl_pkg::*;

  int unsigned warm_cnt;  // clocks since reset release up to the latency
  int unsigned fail_cnt = 0;  // failed assertions

  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i)
      warm_cnt <= 0;
    else if (warm_cnt < PIPE_LAT)
      warm_cnt <= warm_cnt + 1;
  end

  de_after_reset: assert property (@(posedge VCLK_i) $rose(nVRST_i) |-> !de_out_i)
    else begin
      $error("DE_o is high in the first cycle after reset release");
      fail_cnt++;
    end

  sync_delay: assert property (@(posedge VCLK_i) disable iff (!nVRST_i)
    (warm_cnt == PIPE_LAT) |-> (hs_out_i == $past(hs_in_i, PIPE_LAT)) &&
                               (vs_out_i == $past(vs_in_i, PIPE_LAT)) &&
                               (de_out_i == $past(de_in_i, PIPE_LAT)))
    else begin
      $error("sync or DE output does not repeat its input from 9 cycles earlier");
      fail_cnt++;
    end

  blank_passthru: assert property (@(posedge VCLK_i) disable iff (!nVRST_i)
    (warm_cnt == PIPE_LAT && !de_out_i) |-> vdata_out_i == $past(vdata_in_i, PIPE_LAT))
    else begin
      $error("video changed while DE_o is low");
      fail_cnt++;
    end

endmodule

bind scanline_emu tb_scanline_assertions assertions_inst (
  .VCLK_i      (VCLK_i),
  .nVRST_i     (nVRST_i),
  .hs_in_i     (HSYNC_i),
  .vs_in_i     (VSYNC_i),
  .de_in_i     (DE_i),
  .vdata_in_i  (vdata_i),
  .hs_out_i    (HSYNC_o),
  .vs_out_i    (VSYNC_o),
  .de_out_i    (DE_o),
  .vdata_out_i (vdata_o)
);

`default_nettype wire

//--- tb_scanline_emu.sv
// scanline emulator testbench
// lfsr driven video and settings checked against a model of the darkening rules

`default_nettype none

module tb_scanline_emu;

  timeunit 1ns;
  timeprecision 100ps;

  import sl_pkg::*;

  localparam int PHASES         = 6;
  localparam int PHASE_CYCLES   = 300;
  localparam int SEG_CYCLES     = 20;   // settings held this long
  localparam int FLUSH_CYCLES   = PIPE_LAT + 2;
  // reset + 6 x 300 + flush plus margin
  localparam int TIMEOUT_CYCLES = 2200;
  localparam int DRIVE_DLY      = 5;
  localparam logic [31:0] LFSR_SEED = 32'h5824b64d;
  localparam logic [31:0] LFSR_TAPS = 32'ha3000000;

  typedef struct {
    logic        hs;
    logic        vs;
    logic        de;
    logic [23:0] data;
    bit          check;
  } expect_t;

  logic          vclk, nvrst;
  logic          hsync, vsync, de;
  logic [23:0]   vdata;
  logic          sl_en;
  sl_thickness_e sl_thickness;
  sl_profile_e   sl_profile;
  logic [7:0]    sl_rel_pos, sl_strength;
  logic [4:0]    sl_bloom;
  logic          hsync_out, vsync_out, de_out;
  logic [23:0]   vdata_out;

  // next settings go in with the next pixel
  logic          nx_en;
  sl_thickness_e nx_thick;
  sl_profile_e   nx_prof;
  logic [7:0]    nx_rel, nx_str;
  logic [4:0]    nx_bloom;
  bit            cfg_pending;

  logic [31:0] lfsr_q;
  expect_t     exp_q[$];
  int          errors, checks, cycle_cnt;

  tb_clkgen clkgen_inst (.VCLK_o(vclk), .nVRST_o(nvrst));

  scanline_emu scanline_emu_inst (
    .VCLK_i         (vclk),
    .nVRST_i        (nvrst),
    .HSYNC_i        (hsync),
    .VSYNC_i        (vsync),
    .DE_i           (de),
    .vdata_i        (vdata),
    .sl_en_i        (sl_en),
    .sl_thickness_i (sl_thickness),
    .sl_profile_i   (sl_profile),
    .sl_rel_pos_i   (sl_rel_pos),
    .sl_strength_i  (sl_strength),
    .sl_bloom_i     (sl_bloom),
    .HSYNC_o        (hsync_out),
    .VSYNC_o        (vsync_out),
    .DE_o           (de_out),
    .vdata_o        (vdata_out)
  );

  //////////////////////////////////////////////////
  // random source and reference model

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);  // one step per bit
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic int ofs_of(input sl_thickness_e th);
    case (th)
      TH_THIN:  return 'h30;
      TH_THICK: return 'h10;
      default:  return 'h20;
    endcase
  endfunction

  function automatic logic [23:0] model_pixel(input logic [23:0] pix, input logic de_in);
    int          fold, ofs, diff, prof, corr, r, g, b, lref, pre, vref, red, factor, c;
    logic        draw, at_max;
    logic [23:0] out;
    fold = (sl_rel_pos <= 8'h80) ? int'(sl_rel_pos) : 256 - int'(sl_rel_pos);
    ofs  = ofs_of(sl_thickness);
    diff = (fold - ofs) & 'hff;
    if (sl_profile == PR_FLAT) begin
      draw   = fold >= ofs + 'h20;
      at_max = fold > ofs + 'h20;
      prof   = 'h80;
    end else begin  // hann and gauss count as rect
      draw   = fold > ofs;
      at_max = fold >= ofs + 'h40;
      prof   = ((diff & 'h3f) << 2) | ((diff >> 4) & 3);
    end
    draw = draw & sl_en;
    corr = at_max ? int'(sl_strength) : (prof * int'(sl_strength)) >> 8;
    r    = int'(pix[23:16]);
    g    = int'(pix[15:8]);
    b    = int'(pix[7:0]);
    lref = g + ((r + b) >> 1);          // luma approximation
    pre  = (lref * int'(sl_bloom)) >> 5;
    vref = (pre * corr) >> 8;
    red  = (corr < vref) ? 0 : corr - vref;
    factor = 255 - red;
    if (!(de_in && draw))
      return pix;
    for (c = 0; c < 3; c++)
      out[c*8 +: 8] = 8'((int'(pix[c*8 +: 8]) * factor) >> 8);
    return out;
  endfunction

  //////////////////////////////////////////////////
  // stimulus and checks

  task automatic check_outputs(input expect_t e);
    checks++;
    assert (hsync_out === e.hs) else begin
      errors++;
      $display("Fail %0t: HSYNC_o is %b, expected %b", $time, hsync_out, e.hs);
    end
    assert (vsync_out === e.vs) else begin
      errors++;
      $display("Fail %0t: VSYNC_o is %b, expected %b", $time, vsync_out, e.vs);
    end
    assert (de_out === e.de) else begin
      errors++;
      $display("Fail %0t: DE_o is %b, expected %b", $time, de_out, e.de);
    end
    assert (vdata_out === e.data) else begin
      errors++;
      $display("Fail %0t: vdata_o is %h, expected %h", $time, vdata_out, e.data);
    end
  endtask

  task automatic drive_pixel(input logic hs, input logic vs, input logic de_in,
                             input logic [23:0] pix);
    expect_t e;
    @(posedge vclk);
    #(DRIVE_DLY);
    if (exp_q.size() == PIPE_LAT) begin
      e = exp_q.pop_front();
      if (e.check)
        check_outputs(e);
    end
    if (cfg_pending) begin
      foreach (exp_q[i]) exp_q[i].check = 1'b0;  // in flight across the change
      sl_en        = nx_en;
      sl_thickness = nx_thick;
      sl_profile   = nx_prof;
      sl_rel_pos   = nx_rel;
      sl_strength  = nx_str;
      sl_bloom     = nx_bloom;
      cfg_pending  = 1'b0;
    end
    hsync  = hs;
    vsync  = vs;
    de     = de_in;
    vdata  = pix;
    e.hs   = hs;
    e.vs   = vs;
    e.de   = de_in;
    e.data = model_pixel(pix, de_in);
    e.check = 1'b1;
    exp_q.push_back(e);
  endtask

  task automatic pick_config(input int phase, input int seg);
    logic [1:0] pcode;
    logic [7:0] edge_pos;
    nx_en    = 1'b1;
    nx_thick = sl_thickness_e'(2'(rand_bits(2)));
    nx_prof  = PR_RECT;
    nx_rel   = 8'(rand_bits(8));
    nx_str   = 8'(rand_bits(8));
    nx_bloom = 5'(rand_bits(5));
    case (phase)
      0: nx_thick = TH_NORMAL;
      1: begin  // scanline off
        nx_en   = 1'b0;
        nx_prof = sl_profile_e'(2'(rand_bits(2)));
      end
      2: begin
        nx_thick = sl_thickness_e'(2'(seg % 3 + 1));  // thin, normal, thick
        pcode    = 2'(rand_bits(2));
        nx_prof  = (pcode == 2'b11) ? PR_RECT : sl_profile_e'(pcode);
      end
      3: begin
        nx_prof = PR_FLAT;
        if (rand_bits(1) != 0) begin  // aim at the flat-top edge
          edge_pos = 8'(ofs_of(nx_thick) + 'h20 + int'(rand_bits(3)) - 4);
          nx_rel   = (rand_bits(1) != 0) ? edge_pos : 8'h00 - edge_pos;
        end
      end
      4: nx_str = nx_str | 8'h80;
      default: begin  // inside the drawn band
        nx_thick = TH_NORMAL;
        nx_rel   = 8'h40 + 8'(rand_bits(5));
        nx_str   = nx_str | 8'h40;
        nx_bloom = '0;
      end
    endcase
    cfg_pending = 1'b1;
  endtask

  task automatic run_phase(input int phase);
    logic        hs, vs, de_in;
    logic [23:0] pix;
    int          c;
    for (c = 0; c < PHASE_CYCLES; c++) begin
      if (c % SEG_CYCLES == 0)
        pick_config(phase, c / SEG_CYCLES);
      hs    = 1'(rand_bits(1));
      vs    = 1'(rand_bits(1));
      de_in = 1'(rand_bits(1));
      if (phase == 4) begin
        pix = 24'(rand_bits(24)) & 24'h3f3f3f;  // dark
        if (rand_bits(1) != 0)
          pix = pix | 24'hc0c0c0;               // bright
      end else begin
        pix = 24'(rand_bits(24));
      end
      drive_pixel(hs, vs, de_in, pix);
    end
  endtask

  initial begin
    int phase;
    int assert_fails;
    hsync        = 1'b0;
    vsync        = 1'b0;
    de           = 1'b0;
    vdata        = '0;
    sl_en        = 1'b0;
    sl_thickness = TH_DEFAULT;
    sl_profile   = PR_HANN;
    sl_rel_pos   = '0;
    sl_strength  = '0;
    sl_bloom     = '0;
    cfg_pending  = 1'b0;
    lfsr_q       = LFSR_SEED;
    errors       = 0;
    checks       = 0;
    wait (nvrst === 1'b1);
    for (phase = 0; phase < PHASES; phase++)
      run_phase(phase);
    repeat (FLUSH_CYCLES) drive_pixel(1'b0, 1'b0, 1'b0, 24'h0);
    assert_fails = scanline_emu_inst.assertions_inst.fail_cnt;
    $display("errors: %0d, assertion failures: %0d, pixels checked: %0d",
             errors, assert_fails, checks);
    if (errors == 0 && assert_fails == 0 && checks > 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // watchdog
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge vclk);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
sl_pkg.sv
sl_cfg_if.sv
sl_decode.sv
sl_execute.sv
sl_result.sv
scanline_emu.sv
tb_clkgen.sv
tb_scanline_assertions.sv
tb_scanline_emu.sv
